// File: etx.f
+incdir+bench
rtl/etx_pkg.sv
rtl/etx_chan_fifo.sv
rtl/etx_arbiter.sv
rtl/etx_remap.sv
rtl/etx_protocol.sv
rtl/etx.sv
bench/tb_etx.sv

// File: Makefile
# Verilator flow for the etx transmit path testbench

.PHONY: build run clean

build:
	verilator --binary -f etx.f --top-module tb_etx

# Output is shown, the status comes from the pass line search
run: build
	@out="$$(./obj_dir/Vtb_etx)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: bench/etx_model.svh
`ifndef etx_model_svh
`define etx_model_svh

// Expected packets per channel in arrival order
packet_t wr_q [$];
packet_t rd_q [$];
packet_t rr_q [$];

function automatic void push_expected(input chan_t c, input packet_t p);
   case (c)
      chan_wr: wr_q.push_back(p);
      chan_rd: rd_q.push_back(p);
      default: rr_q.push_back(p);
   endcase
endfunction

// Returns 0 when that channel has nothing outstanding
function automatic bit pop_expected(input chan_t c, output packet_t p);
   bit ok;
   ok = 1'b0;
   p  = '0;
   case (c)
      chan_wr: if (wr_q.size() != 0) begin
         p  = wr_q.pop_front();
         ok = 1'b1;
      end
      chan_rd: if (rd_q.size() != 0) begin
         p  = rd_q.pop_front();
         ok = 1'b1;
      end
      default: if (rr_q.size() != 0) begin
         p  = rr_q.pop_front();
         ok = 1'b1;
      end
   endcase
   return ok;
endfunction

function automatic bit queues_empty();
   return (wr_q.size() == 0) && (rd_q.size() == 0) && (rr_q.size() == 0);
endfunction

// Selected upper dstaddr bits take the pattern unless the packet is a read response
function automatic packet_t model_remap(input packet_t p, input chan_t c, input logic en,
                                        input logic [31-remap_lsb:0] pattern,
                                        input logic [31-remap_lsb:0] sel);
   packet_t q;
   q = p;
   if (en && (c != chan_rr)) begin
      for (int i = remap_lsb; i < 32; i++) begin
         if (sel[i-remap_lsb])
            q.dstaddr[i] = pattern[i-remap_lsb];
      end
   end
   return q;
endfunction

function automatic beat_t predict_beat0(input packet_t p);
   return {8'h00, p.ctrlmode, p.datamode, p.write, p.spare, p.dstaddr, 16'h0000};
endfunction

// Packet fields back out of a beat pair
function automatic packet_t rebuild_packet(input beat_t b0, input beat_t b1);
   packet_t p;
   {p.ctrlmode, p.datamode, p.write, p.spare} = b0[55:48];
   p.dstaddr = b0[47:16];
   p.data    = b1[63:32];
   p.srcaddr = b1[31:0];
   return p;
endfunction

`endif

// File: bench/tb_etx.sv
module tb_etx;

   timeunit 1ns;
   timeprecision 100ps;

   import etx_pkg::*;

   `include "etx_model.svh"

   localparam int depth   = 2**fifo_aw;
   localparam int n_rand  = 30;  // Plain traffic per channel
   localparam int n_remap = 20;  // Remap traffic per channel
   localparam int n_hold  = 2;   // Loaded per channel under full pushback
   localparam int n_flow  = 8;   // Unblocked channels during pushback
   localparam int total_packets = 3*n_rand + 3*n_remap + 3*n_hold
                                  + (depth + 2*n_flow) + (n_flow + 2*depth);
   localparam int timeout_cycles = total_packets*20 + 2000;
   localparam int drain_cycles   = 4*2*depth + 20;  // Queued wr and rr packets with margin

   logic clk = 1'b0;
   logic rst;
   logic txwr_access, txrd_access, txrr_access;
   packet_t txwr_packet, txrd_packet, txrr_packet;
   logic txwr_wait, txrd_wait, txrr_wait;
   logic tx_wr_wait, tx_rd_wait;
   logic remap_en;
   logic [31-remap_lsb:0] remap_pattern, remap_sel;
   frame_t tx_frame_par;
   beat_t  tx_data_par;

   string   test_name = "reset";
   int      out_cnt [3] = '{0, 0, 0};  // Packets seen per channel
   chan_t   out_order [$];             // Channel of each packet seen
   logic    in_packet = 1'b0;          // High while beat 1 is due
   beat_t   beat0_q;
   int      snap_a, snap_b;
   logic [31:0] rnd;

   etx etx_inst (.tx_lclk_div4(clk), .*);

   always #4 clk = ~clk;  // 8 ns period

   task automatic step();
      @(posedge clk);
      #1;  // Drive point after the edge
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_packet(input packet_t expected, input packet_t actual);
      if (actual !== expected)
         fail_run($sformatf("[ERROR] %s: packet expected %h actual %h",
                            test_name, expected, actual));
   endtask

   task automatic check_frame(input frame_t expected, input frame_t actual);
      if (actual !== expected)
         fail_run($sformatf("[ERROR] %s: frame expected %h actual %h",
                            test_name, expected, actual));
   endtask

   task automatic check_beat(input beat_t expected, input beat_t actual);
      if (actual !== expected)
         fail_run($sformatf("[ERROR] %s: beat expected %h actual %h",
                            test_name, expected, actual));
   endtask

   task automatic check_order(input chan_t expected, input chan_t actual);
      if (actual !== expected)
         fail_run($sformatf("[ERROR] %s: channel expected %s actual %s",
                            test_name, expected.name(), actual.name()));
   endtask

   function automatic packet_t random_packet(input chan_t c);
      packet_t p;
      logic [31:0] r;
      p.srcaddr         = $urandom;
      p.srcaddr[31:30]  = c;  // Channel tag the DUT never alters
      p.data            = $urandom;
      p.dstaddr         = $urandom;
      r                 = $urandom;
      {p.ctrlmode, p.datamode, p.write, p.spare} = r[7:0];
      return p;
   endfunction

   function automatic logic chan_wait(input chan_t c);
      case (c)
         chan_wr: return txwr_wait;
         chan_rd: return txrd_wait;
         default: return txrr_wait;
      endcase
   endfunction

   task automatic set_access(input chan_t c, input logic a, input packet_t p);
      case (c)
         chan_wr: begin
            txwr_access = a;
            txwr_packet = p;
         end
         chan_rd: begin
            txrd_access = a;
            txrd_packet = p;
         end
         default: begin
            txrr_access = a;
            txrr_packet = p;
         end
      endcase
   endtask

   // Access only in a cycle with wait low
   task automatic send_packets(input chan_t c, input int n);
      packet_t p;
      for (int i = 0; i < n; i++) begin
         p = random_packet(c);
         while (chan_wait(c))
            step();
         set_access(c, 1'b1, p);
         push_expected(c, p);
         step();
         set_access(c, 1'b0, '0);
         repeat ($urandom_range(2, 0))  // Random idle gap
            step();
      end
   endtask

   task automatic wait_drain();
      while (!queues_empty())
         step();
      repeat (4)
         step();
   endtask

   task automatic finish_packet(input beat_t b0, input beat_t b1);
      packet_t got;
      packet_t exp;
      chan_t   c;
      got = rebuild_packet(b0, b1);
      if (got.srcaddr[31:30] == 2'b11)
         fail_run("output packet carries no valid channel tag");
      c = chan_t'(got.srcaddr[31:30]);
      if (!pop_expected(c, exp))
         fail_run($sformatf("unexpected packet on channel %s", c.name()));
      exp = model_remap(exp, c, remap_en, remap_pattern, remap_sel);
      check_packet(exp, got);
      check_beat(predict_beat0(exp), b0);  // Zero bytes around the header
      out_cnt[c]++;
      out_order.push_back(c);
   endtask

   // Beat capture on the falling edge where outputs are settled
   always @(negedge clk) begin
      if (!rst) begin
         if (in_packet) begin
            check_frame(frame_on, tx_frame_par);
            finish_packet(beat0_q, tx_data_par);
            in_packet = 1'b0;
         end else if (tx_frame_par == frame_on) begin
            beat0_q   = tx_data_par;
            in_packet = 1'b1;
         end else begin
            check_frame('0, tx_frame_par);  // Idle link is all zero
            check_beat('0, tx_data_par);
         end
      end
   end

   initial begin
      repeat (timeout_cycles) @(posedge clk);
      fail_run("timeout, the run went past its cycle limit");
   end

   initial begin
      void'($urandom(32'hcf6a_1136));
      rst           = 1'b1;
      txwr_access   = 1'b0;
      txrd_access   = 1'b0;
      txrr_access   = 1'b0;
      txwr_packet   = '0;
      txrd_packet   = '0;
      txrr_packet   = '0;
      tx_wr_wait    = 1'b0;
      tx_rd_wait    = 1'b0;
      remap_en      = 1'b0;
      remap_pattern = '0;
      remap_sel     = '0;
      repeat (4) step();
      rst = 1'b0;

      test_name = "idle_after_reset";
      repeat (20) begin
         step();
         if (txwr_wait || txrd_wait || txrr_wait)
            fail_run("a channel wait output is high with empty FIFOs");
         check_frame('0, tx_frame_par);
         check_beat('0, tx_data_par);
      end

      test_name = "random_traffic";
      fork
         send_packets(chan_wr, n_rand);
         send_packets(chan_rd, n_rand);
         send_packets(chan_rr, n_rand);
      join
      wait_drain();

      test_name = "remap";
      rnd           = $urandom;
      remap_pattern = rnd[31:remap_lsb];
      rnd           = $urandom;
      remap_sel     = rnd[31:remap_lsb];
      remap_en      = 1'b1;
      fork
         send_packets(chan_wr, n_remap);
         send_packets(chan_rd, n_remap);
         send_packets(chan_rr, n_remap);
      join
      wait_drain();
      remap_en = 1'b0;

      test_name = "priority";
      tx_wr_wait = 1'b1;
      tx_rd_wait = 1'b1;
      repeat (4) step();  // Past the synchronizers
      out_order.delete();
      fork
         send_packets(chan_wr, n_hold);
         send_packets(chan_rd, n_hold);
         send_packets(chan_rr, n_hold);
      join
      repeat (4) step();
      if (txwr_wait || txrd_wait || txrr_wait)
         fail_run("a channel wait output is high with two packets queued");
      if (out_order.size() != 0)
         fail_run("packet sent while both pushbacks were high");
      tx_wr_wait = 1'b0;
      tx_rd_wait = 1'b0;
      wait_drain();
      if (out_order.size() != 3*n_hold)
         fail_run("wrong number of packets after pushback release");
      for (int i = 0; i < n_hold; i++) begin
         check_order(chan_rr, out_order[i]);
         check_order(chan_rd, out_order[n_hold+i]);
         check_order(chan_wr, out_order[2*n_hold+i]);
      end

      test_name = "rd_pushback";
      tx_rd_wait = 1'b1;
      repeat (20) step();
      snap_a = out_cnt[chan_rd];
      fork
         send_packets(chan_rd, depth);
         send_packets(chan_wr, n_flow);
         send_packets(chan_rr, n_flow);
      join
      while ((wr_q.size() != 0) || (rr_q.size() != 0))
         step();
      if (out_cnt[chan_rd] != snap_a)
         fail_run("read request sent while read pushback was high");
      if (!txrd_wait)
         fail_run("txrd_wait is low with a full read request FIFO");
      tx_rd_wait = 1'b0;
      wait_drain();

      test_name = "wr_pushback";
      tx_wr_wait = 1'b1;
      repeat (20) step();
      snap_a = out_cnt[chan_wr];
      snap_b = out_cnt[chan_rr];
      fork
         send_packets(chan_rd, n_flow);
         send_packets(chan_wr, depth);
         send_packets(chan_rr, depth);
      join
      while (rd_q.size() != 0)
         step();
      if ((out_cnt[chan_wr] != snap_a) || (out_cnt[chan_rr] != snap_b))
         fail_run("write or read response sent while write pushback was high");
      if (!txwr_wait || !txrr_wait)
         fail_run("txwr_wait or txrr_wait is low with a full FIFO");
      tx_wr_wait = 1'b0;
      for (int i = 0; (i < drain_cycles) && !queues_empty(); i++)
         step();
      repeat (4)
         step();

      if (!queues_empty())
         fail_run("queued packets did not all arrive after pushback release");
      else
         $display("Result: PASSED");
      $finish;
   end

endmodule

// File: rtl/etx.sv
module etx (
   input  logic                            tx_lclk_div4,   // Parallel clock
   input  logic                            rst,            // Sync, active high
   // Write channel
   input  logic                            txwr_access,
   input  etx_pkg::packet_t                txwr_packet,
   output logic                            txwr_wait,
   // Read request channel
   input  logic                            txrd_access,
   input  etx_pkg::packet_t                txrd_packet,
   output logic                            txrd_wait,
   // Read response channel
   input  logic                            txrr_access,
   input  etx_pkg::packet_t                txrr_packet,
   output logic                            txrr_wait,
   // Far end pushback, async
   input  logic                            tx_wr_wait,
   input  logic                            tx_rd_wait,
   // Address remap controls
   input  logic                            remap_en,
   input  logic [31-etx_pkg::remap_lsb:0]  remap_pattern,
   input  logic [31-etx_pkg::remap_lsb:0]  remap_sel,
   // Parallel link output
   output etx_pkg::frame_t                 tx_frame_par,
   output etx_pkg::beat_t                  tx_data_par
);

   import etx_pkg::*;

   logic    wr_ready, rd_ready, rr_ready;  // FIFO not empty
   logic    wr_pop, rd_pop, rr_pop;        // Arbiter pop strobes
   packet_t wr_head, rd_head, rr_head;
   logic    arb_valid;                     // Arbiter to remap
   packet_t arb_packet;
   logic    arb_rr;
   logic    rmp_valid;                     // Remap to protocol
   packet_t rmp_packet;

   etx_chan_fifo txwr_fifo (
      .tx_lclk_div4 (tx_lclk_div4),
      .rst          (rst),
      .access       (txwr_access),
      .packet       (txwr_packet),
      .pop          (wr_pop),
      .full_wait    (txwr_wait),
      .ready        (wr_ready),
      .head         (wr_head)
   );

   etx_chan_fifo txrd_fifo (
      .tx_lclk_div4 (tx_lclk_div4),
      .rst          (rst),
      .access       (txrd_access),
      .packet       (txrd_packet),
      .pop          (rd_pop),
      .full_wait    (txrd_wait),
      .ready        (rd_ready),
      .head         (rd_head)
   );

   etx_chan_fifo txrr_fifo (
      .tx_lclk_div4 (tx_lclk_div4),
      .rst          (rst),
      .access       (txrr_access),
      .packet       (txrr_packet),
      .pop          (rr_pop),
      .full_wait    (txrr_wait),
      .ready        (rr_ready),
      .head         (rr_head)
   );

   etx_arbiter etx_arbiter (
      .tx_lclk_div4 (tx_lclk_div4),
      .rst          (rst),
      .wr_ready     (wr_ready),
      .rd_ready     (rd_ready),
      .rr_ready     (rr_ready),
      .wr_head      (wr_head),
      .rd_head      (rd_head),
      .rr_head      (rr_head),
      .tx_wr_wait   (tx_wr_wait),
      .tx_rd_wait   (tx_rd_wait),
      .wr_pop       (wr_pop),
      .rd_pop       (rd_pop),
      .rr_pop       (rr_pop),
      .arb_valid    (arb_valid),
      .arb_packet   (arb_packet),
      .arb_rr       (arb_rr)
   );

   etx_remap etx_remap (
      .tx_lclk_div4  (tx_lclk_div4),
      .rst           (rst),
      .arb_valid     (arb_valid),
      .arb_packet    (arb_packet),
      .arb_rr        (arb_rr),
      .remap_en      (remap_en),
      .remap_pattern (remap_pattern),
      .remap_sel     (remap_sel),
      .rmp_valid     (rmp_valid),
      .rmp_packet    (rmp_packet)
   );

   etx_protocol etx_protocol (
      .tx_lclk_div4 (tx_lclk_div4),
      .rst          (rst),
      .rmp_valid    (rmp_valid),
      .rmp_packet   (rmp_packet),
      .tx_frame_par (tx_frame_par),
      .tx_data_par  (tx_data_par)
   );

endmodule

// File: rtl/etx_protocol.sv
module etx_protocol (
   input  logic             tx_lclk_div4,  // Parallel clock
   input  logic             rst,           // Sync, active high
   input  logic             rmp_valid,     // Start of a packet
   input  etx_pkg::packet_t rmp_packet,
   output etx_pkg::frame_t  tx_frame_par,  // Frame byte per beat
   output etx_pkg::beat_t   tx_data_par    // Parallel data beat
);

   import etx_pkg::*;

   packet_t pkt_q;     // Held for the second beat
   logic    beat_cnt;  // High while beat 1 is pending
   frame_t  ctrl;      // Control byte of beat 0
   beat_t   beat0;
   beat_t   beat1;

   assign ctrl = {rmp_packet.ctrlmode,
                  rmp_packet.datamode,
                  rmp_packet.write,
                  rmp_packet.spare};

   // Header beat, built straight from the incoming packet
   assign beat0 = {8'h00,
                   ctrl,
                   rmp_packet.dstaddr,
                   16'h0000};

   // Payload beat, from the held packet
   assign beat1 = {pkt_q.data,
                   pkt_q.srcaddr};

   always_ff @(posedge tx_lclk_div4) begin
      if (rst) begin
         beat_cnt     <= 1'b0;
         tx_frame_par <= '0;
         tx_data_par  <= '0;
      end else if (rmp_valid) begin
         beat_cnt     <= 1'b1;      // Beat 1 follows next cycle
         tx_frame_par <= frame_on;
         tx_data_par  <= beat0;
      end else if (beat_cnt) begin
         beat_cnt     <= 1'b0;
         tx_frame_par <= frame_on;
         tx_data_par  <= beat1;
      end else begin
         tx_frame_par <= '0;        // Idle link
         tx_data_par  <= '0;
      end
   end

   // Packet hold register
   always_ff @(posedge tx_lclk_div4) begin
      if (rmp_valid)
         pkt_q <= rmp_packet;
   end

   // Strobes from remap are at least two cycles apart
   // so beat 1 never collides with the next beat 0

endmodule

// File: rtl/etx_remap.sv
module etx_remap (
   input  logic                            tx_lclk_div4,   // Parallel clock
   input  logic                            rst,            // Sync, active high
   input  logic                            arb_valid,      // Issue strobe
   input  etx_pkg::packet_t                arb_packet,
   input  logic                            arb_rr,         // Bypass for read responses
   input  logic                            remap_en,
   input  logic [31-etx_pkg::remap_lsb:0]  remap_pattern,  // Replacement bits
   input  logic [31-etx_pkg::remap_lsb:0]  remap_sel,      // Which bits to replace
   output logic                            rmp_valid,      // Arb strobe delayed one cycle
   output etx_pkg::packet_t                rmp_packet
);

   import etx_pkg::*;

   logic [31-remap_lsb:0] dst_hi;    // Upper dstaddr after remap
   packet_t               remapped;

   // Replace selected upper bits with the pattern
   always_comb begin
      dst_hi = arb_packet.dstaddr[31:remap_lsb];
      if (remap_en && !arb_rr)
         dst_hi = (remap_pattern & remap_sel) | (dst_hi & ~remap_sel);
   end

   always_comb begin
      remapped                          = arb_packet;  // Other fields pass as is
      remapped.dstaddr[31:remap_lsb]    = dst_hi;
   end

   always_ff @(posedge tx_lclk_div4) begin
      if (rst)
         rmp_valid <= 1'b0;
      else
         rmp_valid <= arb_valid;
   end

   // Payload register
   always_ff @(posedge tx_lclk_div4) begin
      if (arb_valid)
         rmp_packet <= remapped;
   end

endmodule

// File: rtl/etx_arbiter.sv
module etx_arbiter (
   input  logic             tx_lclk_div4,  // Parallel clock
   input  logic             rst,           // Sync, active high
   input  logic             wr_ready,      // Write FIFO not empty
   input  logic             rd_ready,      // Read request FIFO not empty
   input  logic             rr_ready,      // Read response FIFO not empty
   input  etx_pkg::packet_t wr_head,
   input  etx_pkg::packet_t rd_head,
   input  etx_pkg::packet_t rr_head,
   input  logic             tx_wr_wait,    // Async write pushback
   input  logic             tx_rd_wait,    // Async read pushback
   output logic             wr_pop,        // One-cycle pop strobes
   output logic             rd_pop,
   output logic             rr_pop,
   output logic             arb_valid,     // Issue strobe, cycle after pick
   output etx_pkg::packet_t arb_packet,
   output logic             arb_rr         // Issued packet is a read response
);

   import etx_pkg::*;

   logic [1:0] wr_wait_sync;  // Two-flop synchronizers
   logic [1:0] rd_wait_sync;
   logic       wr_blk;        // Blocks wr and rr
   logic       rd_blk;        // Blocks rd only
   chan_t      pick;          // Winning channel this cycle
   logic       pick_ok;       // A channel won this cycle
   packet_t    pick_packet;

   assign wr_blk = wr_wait_sync[1];
   assign rd_blk = rd_wait_sync[1];

   // Fixed priority rr > rd > wr, idle cycle required between picks
   always_comb begin
      pick    = chan_wr;
      pick_ok = 1'b0;
      if (!arb_valid) begin
         if (rr_ready && !wr_blk) begin
            pick    = chan_rr;
            pick_ok = 1'b1;
         end else if (rd_ready && !rd_blk) begin
            pick    = chan_rd;
            pick_ok = 1'b1;
         end else if (wr_ready && !wr_blk) begin
            pick    = chan_wr;
            pick_ok = 1'b1;
         end
      end
   end

   always_comb begin
      case (pick)
         chan_rr: pick_packet = rr_head;
         chan_rd: pick_packet = rd_head;
         default: pick_packet = wr_head;
      endcase
   end

   assign rr_pop = pick_ok && (pick == chan_rr);
   assign rd_pop = pick_ok && (pick == chan_rd);
   assign wr_pop = pick_ok && (pick == chan_wr);

   always_ff @(posedge tx_lclk_div4) begin
      if (rst) begin
         wr_wait_sync <= 2'b00;
         rd_wait_sync <= 2'b00;
         arb_valid    <= 1'b0;
         arb_rr       <= 1'b0;
      end else begin
         wr_wait_sync <= {wr_wait_sync[0], tx_wr_wait};
         rd_wait_sync <= {rd_wait_sync[0], tx_rd_wait};
         arb_valid    <= pick_ok;             // Picked packet always issues
         arb_rr       <= pick_ok && (pick == chan_rr);
      end
   end

   // Issued packet, loaded with the pop
   always_ff @(posedge tx_lclk_div4) begin
      if (pick_ok)
         arb_packet <= pick_packet;
   end

endmodule

// File: rtl/etx_chan_fifo.sv
module etx_chan_fifo #(
   parameter int aw = etx_pkg::fifo_aw  // log2 of depth
) (
   input  logic             tx_lclk_div4,  // Parallel clock
   input  logic             rst,           // Sync, active high
   input  logic             access,        // Write strobe from sender
   input  etx_pkg::packet_t packet,        // Packet written on access
   input  logic             pop,           // Head consumed on this edge
   output logic             full_wait,     // Registered full flag to sender
   output logic             ready,         // At least one packet held
   output etx_pkg::packet_t head           // Oldest packet
);

   import etx_pkg::*;

   logic [pw-1:0] mem [2**aw];  // Packet storage
   logic [aw-1:0] wr_ptr;       // Next slot to write
   logic [aw-1:0] rd_ptr;       // Oldest slot
   logic [aw:0]   count;        // Packets held, 0 to depth
   logic [aw:0]   count_nxt;
   logic          do_wr;
   logic          do_rd;

   assign do_wr = access && !full_wait;  // Access while full is lost
   assign do_rd = pop && ready;          // Pop on empty is ignored

   assign ready = (count != '0);
   assign head  = packet_t'(mem[rd_ptr]);

   // Occupancy after this edge
   always_comb begin
      count_nxt = count;
      if (do_wr && !do_rd)
         count_nxt = count + 1'b1;
      else if (!do_wr && do_rd)
         count_nxt = count - 1'b1;
   end

   always_ff @(posedge tx_lclk_div4) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         full_wait <= 1'b0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count     <= count_nxt;
         full_wait <= count_nxt[aw];  // MSB set only at full depth
      end
   end

   // Storage write port
   always_ff @(posedge tx_lclk_div4) begin
      if (do_wr)
         mem[wr_ptr] <= packet;
   end

endmodule

// File: rtl/etx_pkg.sv
package etx_pkg;

   // Packet geometry
   localparam int pw        = 104;  // Full elink packet width
   localparam int fifo_aw   = 2;    // Default FIFO address width, 4 entries
   localparam int remap_lsb = 20;   // Bits [31:20] of dstaddr are remappable

   // Parallel output lane types
   typedef logic [7:0]  frame_t;    // One frame byte per parallel beat
   typedef logic [63:0] beat_t;     // Eight data bytes per parallel beat

   localparam frame_t frame_on = 8'hff;  // Frame byte while a packet beat is sent

   // Elink packet, srcaddr in the top bits
   typedef struct packed {
      logic [31:0] srcaddr;   // Return address for reads
      logic [31:0] data;      // Write data or read response data
      logic [31:0] dstaddr;   // Target address, upper bits remappable
      logic [3:0]  ctrlmode;  // Routing and special transaction modes
      logic [1:0]  datamode;  // Transfer size, byte to double
      logic        write;     // High for writes and read responses
      logic        spare;     // Unused in this path, sent as is
   } packet_t;

   // Transmit channels, wr has the lowest priority
   typedef enum logic [1:0] {
      chan_wr,  // Write channel
      chan_rd,  // Read request channel
      chan_rr   // Read response channel
   } chan_t;

   // Beat 0 carries the header, beat 1 the payload
   // Beat 0 layout, MSB first
   //   [63:56] zero
   //   [55:48] ctrlmode, datamode, write, spare
   //   [47:16] dstaddr
   //   [15:0]  zero
   // Beat 1 layout, MSB first
   //   [63:32] data
   //   [31:0]  srcaddr
   //
   // Read requests obey the far end's read pushback
   // Writes and read responses obey its write pushback
   //
   // Channel FIFOs only hold whole packets
   // There is no partial packet state anywhere in the pipeline

endpackage
